//--- if_fetch.f
verilog/if_stage_pkg.sv
verilog/fetch_unit.sv
verilog/dummy_instr_gen.sv
verilog/if_id_pipe.sv
verilog/if_stage.sv
verification/if_stage_checks.sv
verification/if_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the IF stage simulation with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module if_stage_tb --Mdir "$OBJ" -f if_fetch.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vif_stage_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
if ! grep -q "Finished with no errors" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

//--- verification/if_stage_checks.sv
// Checker for the IF stage outputs; expects kill with every PC set and dummy_every fixed per run
`timescale 1ns/100ps

module if_stage_checks (
  input  logic                  clk,
  input  logic                  rst_n,
  input  int                    test_id_i,        // Test that errors count against
  input  logic                  pc_set_i,
  input  if_stage_pkg::pc_mux_e pc_mux_i,
  input  if_stage_pkg::addr_t   boot_addr_i,
  input  if_stage_pkg::addr_t   jump_target_i,
  input  if_stage_pkg::addr_t   branch_target_i,
  input  if_stage_pkg::addr_t   mepc_i,
  input  if_stage_pkg::addr_t   dpc_i,
  input  if_stage_pkg::addr_t   dm_halt_addr_i,
  input  if_stage_pkg::addr_t   nmi_addr_i,
  input  if_stage_pkg::mtvec_t  mtvec_addr_i,
  input  if_stage_pkg::irq_id_t irq_id_i,
  input  logic                  halt_if_i,
  input  logic                  id_ready_i,
  input  logic                  dummy_en_i,
  input  logic [3:0]            dummy_every_i,
  input  logic                  instr_req_i,      // Memory bus request
  input  logic                  instr_rvalid_i,   // Memory bus response
  input  logic                  if_busy_i,
  input  logic                  if_valid_i,
  input  logic                  id_instr_valid_i,
  input  if_stage_pkg::instr_t  id_instr_i,
  input  if_stage_pkg::addr_t   id_pc_i,
  input  logic                  id_dummy_i,
  input  logic                  lfsr_shift_i,
  input  logic                  csr_mtvec_init_i
);

  import if_stage_pkg::*;

  int    err_cnt [0:5];   // Failures per test
  logic  xfer_q;          // ID holds a freshly transferred item
  logic  xfer_en_q;       // Dummy enable at that transfer
  logic  exp_known;       // Set by the first PC set
  addr_t exp_pc;          // Next real PC expected in ID
  int    real_cnt;        // Real items since the last dummy
  logic  pend_q;          // Request sent and not yet answered

  function automatic string test_name(input int id);
    case (id)
      0: test_name = "pc_set_all";
      1: test_name = "sequential";
      2: test_name = "random_ready";
      3: test_name = "dummy_insert";
      4: test_name = "kill_outstanding";
      default: test_name = "halt";
    endcase
  endfunction

  // Target address straight from the PC source rules
  function automatic addr_t target_of(input pc_mux_e sel);
    case (sel)
      PC_BOOT:     target_of = boot_addr_i & ~32'h3;
      PC_JUMP:     target_of = jump_target_i;
      PC_BRANCH:   target_of = branch_target_i;
      PC_MRET:     target_of = mepc_i;
      PC_DRET:     target_of = dpc_i;
      PC_TRAP_EXC: target_of = {mtvec_addr_i, 8'h00};
      PC_TRAP_IRQ: target_of = {mtvec_addr_i, 8'h00} | (32'(irq_id_i) << 2);
      PC_TRAP_DBG: target_of = dm_halt_addr_i & ~32'h3;
      default:     target_of = nmi_addr_i & ~32'h3;
    endcase
  endfunction

  // Memory word is the address times 32 with an OP-IMM opcode
  function automatic instr_t mem_word(input addr_t a);
    mem_word = ((a << 5) & 32'hFFFF_FF80) | 32'h0000_0013;
  endfunction

  task automatic record_error(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    err_cnt[test_id_i]++;
    $display("ERROR %s: %s expected %h actual %h", test_name(test_id_i), what, exp_v, act_v);
  endtask

  task automatic note_fault(input string what);
    err_cnt[test_id_i]++;
    $display("ERROR %s: %s", test_name(test_id_i), what);
  endtask

  initial begin
    for (int i = 0; i < 6; i++) begin
      err_cnt[i] = 0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference bookkeeping
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      xfer_q    <= 1'b0;
      xfer_en_q <= 1'b0;
      exp_known <= 1'b0;
      exp_pc    <= '0;
      real_cnt  <= 0;
      pend_q    <= 1'b0;
    end else begin
      xfer_q    <= if_valid_i && id_ready_i;
      xfer_en_q <= dummy_en_i;
      if (xfer_q && !id_dummy_i) exp_pc <= exp_pc + 32'd4;  // Sequential successor
      if (pc_set_i) begin
        exp_pc    <= target_of(pc_mux_i);  // New stream wins
        exp_known <= 1'b1;
      end
      if (xfer_q) begin
        real_cnt <= (id_dummy_i || !xfer_en_q) ? 0 : real_cnt + 1;
      end else if (!dummy_en_i) begin
        real_cnt <= 0;
      end
      if (instr_req_i) begin
        pend_q <= 1'b1;  // Memory now owes a response
      end else if (instr_rvalid_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  a_pc_order : assert property (@(posedge clk) disable iff (!rst_n)
    xfer_q && !id_dummy_i && exp_known |-> id_pc_i == exp_pc)
    else record_error("id_pc_o", $sampled(exp_pc), $sampled(id_pc_i));

  a_instr_data : assert property (@(posedge clk) disable iff (!rst_n)
    xfer_q && !id_dummy_i |-> id_instr_i == mem_word(id_pc_i))
    else record_error("id_instr_o", mem_word($sampled(id_pc_i)), $sampled(id_instr_i));

  a_mtvec_init : assert property (@(posedge clk) disable iff (!rst_n)
    csr_mtvec_init_i == (pc_set_i && pc_mux_i == PC_BOOT))
    else record_error("csr_mtvec_init_o", 32'($sampled(pc_set_i && pc_mux_i == PC_BOOT)),
                      32'($sampled(csr_mtvec_init_i)));

  // Busy covers the request cycle up to and including the response
  a_busy : assert property (@(posedge clk) disable iff (!rst_n)
    if_busy_i == (instr_req_i || pend_q))
    else record_error("if_busy_o", 32'($sampled(instr_req_i || pend_q)),
                      32'($sampled(if_busy_i)));

  a_id_frozen : assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable({id_instr_valid_i, id_instr_i, id_pc_i, id_dummy_i}))
    else note_fault("ID outputs changed while id_ready_i was low");

  a_dummy_shape : assert property (@(posedge clk) disable iff (!rst_n)
    xfer_q && id_dummy_i |-> id_instr_i[6:0] == OPCODE_OP && id_instr_i[11:7] == 5'd0
                             && id_instr_i[31:25] == 7'd0)
    else note_fault("dummy instruction is not an OP with rd x0 and funct7 zero");

  a_dummy_spacing : assert property (@(posedge clk) disable iff (!rst_n)
    xfer_q && id_dummy_i |-> real_cnt == int'(dummy_every_i))
    else record_error("real items before dummy", 32'($sampled(dummy_every_i)),
                      32'($sampled(real_cnt)));

  a_dummy_due : assert property (@(posedge clk) disable iff (!rst_n)
    xfer_q && !id_dummy_i && xfer_en_q |-> real_cnt < int'(dummy_every_i))
    else note_fault("real instruction delivered where a dummy was due");

  a_shift_to_dummy : assert property (@(posedge clk) disable iff (!rst_n)
    lfsr_shift_i |=> $rose(id_dummy_i))
    else note_fault("lfsr_shift_o not followed by a rising id_dummy_o");

  a_halt_clears : assert property (@(posedge clk) disable iff (!rst_n)
    halt_if_i && id_ready_i |=> !id_instr_valid_i)
    else note_fault("id_instr_valid_o high in the second cycle of halt");

endmodule

//--- verification/if_stage_tb.sv
// Testbench for the IF stage; memory answers after 1 to 4 cycles, every PC set comes with kill
`timescale 1ns/100ps

module if_stage_tb;

  import if_stage_pkg::*;

  localparam int ITEMS       = 115;                   // Items over all phases
  localparam int STIM_CYCLES = ITEMS * 7 + 20;        // Worst case at full ready
  localparam int WDOG_CYCLES = STIM_CYCLES * 5 + 200;

  logic clk, rst_n;
  logic pc_set_i, kill_if_i, halt_if_i, id_ready_i, dummy_en_i;
  pc_mux_e pc_mux_i;
  addr_t boot_addr_i, jump_target_i, branch_target_i, mepc_i, dpc_i;
  addr_t dm_halt_addr_i, nmi_addr_i;
  mtvec_t mtvec_addr_i;
  irq_id_t irq_id_i;
  logic [3:0] dummy_every_i;
  logic instr_req_o, instr_rvalid_i, if_valid_o, id_instr_valid_o, id_dummy_o;
  logic lfsr_shift_o, csr_mtvec_init_o, if_busy_o;
  addr_t instr_addr_o, id_pc_o, mem_addr;
  instr_t instr_rdata_i, id_instr_o;
  int test_id, mem_wait, total;
  integer seed = 32'hb7f5;

  if_stage UUT (.*);

  if_stage_checks u_checks (
    .clk (clk), .rst_n (rst_n), .test_id_i (test_id), .pc_set_i (pc_set_i),
    .pc_mux_i (pc_mux_i), .boot_addr_i (boot_addr_i), .jump_target_i (jump_target_i),
    .branch_target_i (branch_target_i), .mepc_i (mepc_i), .dpc_i (dpc_i),
    .dm_halt_addr_i (dm_halt_addr_i), .nmi_addr_i (nmi_addr_i),
    .mtvec_addr_i (mtvec_addr_i), .irq_id_i (irq_id_i), .halt_if_i (halt_if_i),
    .id_ready_i (id_ready_i), .dummy_en_i (dummy_en_i), .dummy_every_i (dummy_every_i),
    .instr_req_i (instr_req_o), .instr_rvalid_i (instr_rvalid_i), .if_busy_i (if_busy_o),
    .if_valid_i (if_valid_o), .id_instr_valid_i (id_instr_valid_o),
    .id_instr_i (id_instr_o), .id_pc_i (id_pc_o), .id_dummy_i (id_dummy_o),
    .lfsr_shift_i (lfsr_shift_o), .csr_mtvec_init_i (csr_mtvec_init_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Memory model with one request at a time
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      mem_wait       <= 0;
      mem_addr       <= '0;
      instr_rvalid_i <= 1'b0;
      instr_rdata_i  <= '0;
    end else begin
      instr_rvalid_i <= 1'b0;
      if (mem_wait == 1) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= ((mem_addr << 5) & 32'hFFFF_FF80) | 32'h13;  // Never an OP
      end
      if (mem_wait > 0) mem_wait <= mem_wait - 1;
      if (instr_req_o) begin
        mem_addr <= instr_addr_o;
        mem_wait <= 1 + int'($unsigned($random(seed)) % 4);  // 1 to 4 cycles
      end
    end
  end

  // Redirect with kill as the controller does
  task automatic set_pc(input pc_mux_e sel);
    pc_set_i  <= 1'b1;
    pc_mux_i  <= sel;
    kill_if_i <= 1'b1;
    @(posedge clk);
    pc_set_i  <= 1'b0;
    kill_if_i <= 1'b0;
  endtask

  // Waits for n IF transfers and optionally toggles id_ready_i at random
  task automatic wait_items(input int n, input bit rand_ready);
    int got;
    got = 0;
    while (got < n) begin
      @(posedge clk);
      if (if_valid_o && id_ready_i) got++;
      if (rand_ready) id_ready_i <= $random(seed) & 1;
    end
    id_ready_i <= 1'b1;
  endtask

  task automatic finish_test();
    $display("Test %0d %s done, %0d errors", test_id, u_checks.test_name(test_id),
             u_checks.err_cnt[test_id]);
  endtask

  initial begin
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    pc_mux_i        = PC_BOOT;
    kill_if_i       = 1'b0;
    halt_if_i       = 1'b0;
    id_ready_i      = 1'b1;
    dummy_en_i      = 1'b0;
    dummy_every_i   = 4'd3;
    boot_addr_i     = 32'h1003;
    jump_target_i   = 32'h2000;
    branch_target_i = 32'h3000;
    mepc_i          = 32'h4000;
    dpc_i           = 32'h5000;
    dm_halt_addr_i  = 32'h6002;
    nmi_addr_i      = 32'h7001;
    mtvec_addr_i    = 24'h000090;
    irq_id_i        = 5'd3;
    test_id = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int m = 0; m < 9; m++) begin  // Every PC source
      set_pc(pc_mux_e'(m));
      wait_items(3, 1'b0);
    end
    finish_test();
    test_id = 1;
    set_pc(PC_BOOT);
    wait_items(20, 1'b0);
    finish_test();
    test_id = 2;
    wait_items(30, 1'b1);
    finish_test();
    test_id = 3;
    id_ready_i <= 1'b0;  // No transfer while the enable changes
    repeat (2) @(posedge clk);
    dummy_en_i <= 1'b1;
    @(posedge clk);
    id_ready_i <= 1'b1;
    wait_items(24, 1'b0);
    id_ready_i <= 1'b0;
    repeat (2) @(posedge clk);
    dummy_en_i <= 1'b0;
    @(posedge clk);
    id_ready_i <= 1'b1;
    finish_test();
    test_id = 4;
    for (int k = 0; k < 3; k++) begin
      set_pc(PC_JUMP);
      @(posedge clk);
      while (!if_busy_o) @(posedge clk);
      set_pc(PC_MRET);  // Old jump stream must not reach ID
      wait_items(4, 1'b0);
    end
    finish_test();
    test_id = 5;
    halt_if_i <= 1'b1;
    repeat (6) @(posedge clk);
    halt_if_i <= 1'b0;
    wait_items(2, 1'b0);
    finish_test();
    total = 0;
    for (int i = 0; i < 6; i++) total += u_checks.err_cnt[i];
    $display("Tests run: 6, errors: %0d", total);
    if (total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from the stimulus length
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Timeout: test %0d did not finish in time", test_id);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- verilog/dummy_instr_gen.sv
// dummy_every_i must be non-zero and LFSR_SEED non-zero; only real instructions advance the count
`timescale 1ns/100ps

module dummy_instr_gen #(
  parameter int unsigned DUMMY_CNT_W = 4,
  parameter logic [31:0] LFSR_SEED   = 32'h5A3C_96E1
) (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   dummy_en_i,
  input  logic [DUMMY_CNT_W-1:0] dummy_every_i,  // Real instructions per dummy
  input  logic                   instr_issued_i,  // IF to ID transfer

  output logic                   dummy_insert_o,
  output if_stage_pkg::instr_t   dummy_instr_o,
  output logic                   lfsr_shift_o
);

  import if_stage_pkg::*;

  // x^32 + x^22 + x^2 + x + 1, right shifting Galois form
  localparam logic [31:0]            LFSR_TAPS = 32'h8020_0003;
  localparam logic [DUMMY_CNT_W-1:0] CNT_ONE   = 1;
  localparam reg_idx_t               RD_X0     = '0;

  logic [DUMMY_CNT_W-1:0] cnt_q;
  logic [31:0]            lfsr_q;
  logic [31:0]            lfsr_n;
  logic                   dummy_issued;
  reg_idx_t               rs1;
  reg_idx_t               rs2;
  logic [2:0]             funct3;

  //////////////////////////////////////////////////////////////////////
  // Issue counter
  //////////////////////////////////////////////////////////////////////

  assign dummy_insert_o = dummy_en_i && (cnt_q == dummy_every_i);  // Held until issued
  assign dummy_issued   = instr_issued_i && dummy_insert_o;

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (!dummy_en_i) begin
      cnt_q <= '0;                // Restart cleanly on enable
    end else if (dummy_issued) begin
      cnt_q <= '0;
    end else if (instr_issued_i) begin
      cnt_q <= cnt_q + CNT_ONE;   // One more real instruction
    end
  end

  //////////////////////////////////////////////////////////////////////
  // LFSR
  //////////////////////////////////////////////////////////////////////

  // Feedback into the tap positions when bit 0 falls out
  assign lfsr_n = (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q <= LFSR_SEED;
    end else if (dummy_issued) begin
      lfsr_q <= lfsr_n;
    end
  end

  assign lfsr_shift_o = dummy_issued;  // One shift per dummy

  // Random operands, result goes to x0
  assign funct3 = lfsr_q[2:0];
  assign rs1    = lfsr_q[7:3];
  assign rs2    = lfsr_q[12:8];

  assign dummy_instr_o = {7'b0000000, rs2, rs1, funct3, RD_X0, OPCODE_OP};

  // An all-zero LFSR would lock up
  a_lfsr_nonzero : assert property (
    @(posedge clk) disable iff (!rst_n)
    lfsr_q != 32'h0
  ) else $error("Dummy LFSR reached zero");

endmodule

//--- verilog/fetch_unit.sv
// One outstanding request only; a PC set during a pending request waits out the stale response
`timescale 1ns/100ps

module fetch_unit (
  input  logic                  clk,
  input  logic                  rst_n,

  // PC set from the controller
  input  logic                  pc_set_i,
  input  if_stage_pkg::pc_mux_e pc_mux_i,

  // Target addresses
  input  if_stage_pkg::addr_t   boot_addr_i,
  input  if_stage_pkg::addr_t   jump_target_i,
  input  if_stage_pkg::addr_t   branch_target_i,
  input  if_stage_pkg::addr_t   mepc_i,
  input  if_stage_pkg::addr_t   dpc_i,
  input  if_stage_pkg::addr_t   dm_halt_addr_i,
  input  if_stage_pkg::addr_t   nmi_addr_i,
  input  if_stage_pkg::mtvec_t  mtvec_addr_i,
  input  if_stage_pkg::irq_id_t irq_id_i,

  input  logic                  fetch_ready_i,   // IF takes the held instruction

  // Memory bus
  output logic                  instr_req_o,
  output if_stage_pkg::addr_t   instr_addr_o,
  input  logic                  instr_rvalid_i,
  input  if_stage_pkg::instr_t  instr_rdata_i,

  // Towards the IF/ID pipe
  output logic                  fetch_valid_o,
  output if_stage_pkg::instr_t  fetch_instr_o,
  output if_stage_pkg::addr_t   fetch_pc_o,

  output logic                  csr_mtvec_init_o,
  output logic                  busy_o
);

  import if_stage_pkg::*;

  addr_t        target_addr;           // Selected PC set target
  fetch_state_e state_q, state_n;
  addr_t        addr_q, addr_n;        // Request address, later PC of the held word
  logic         req_q, req_n;          // Registered request pulse
  logic         discard_q, discard_n;  // Outstanding response is stale
  logic         load_instr;
  instr_t       instr_q;

  //////////////////////////////////////////////////////////////////////
  // Target address selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT:     target_addr = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:     target_addr = jump_target_i;
      PC_BRANCH:   target_addr = branch_target_i;
      PC_MRET:     target_addr = mepc_i;           // Back to the trapped instruction
      PC_DRET:     target_addr = dpc_i;
      PC_TRAP_EXC: target_addr = {mtvec_addr_i, 8'h00};  // Common exception entry
      PC_TRAP_IRQ: target_addr = {mtvec_addr_i, 1'b0, irq_id_i, 2'b00};  // Vectored
      PC_TRAP_DBG: target_addr = {dm_halt_addr_i[31:2], 2'b00};
      PC_NMI:      target_addr = {nmi_addr_i[31:2], 2'b00};
      default:     target_addr = {boot_addr_i[31:2], 2'b00};  // Unused encodings
    endcase
  end

  // Let the CSR file set up mtvec on boot
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  //////////////////////////////////////////////////////////////////////
  // Fetch sequencer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n    = state_q;
    addr_n     = addr_q;
    req_n      = 1'b0;
    discard_n  = discard_q;
    load_instr = 1'b0;

    if (pc_set_i) begin
      addr_n = target_addr;
      if ((state_q == WAIT_RESP) && !instr_rvalid_i) begin
        discard_n = 1'b1;  // Old response still in flight
      end else begin
        // Nothing pending, or the pending word arrives now and is dropped
        req_n     = 1'b1;
        state_n   = WAIT_RESP;
        discard_n = 1'b0;
      end
    end else begin
      unique case (state_q)
        IDLE: begin
          state_n = IDLE;  // No fetch before the first PC set
        end
        WAIT_RESP: begin
          if (instr_rvalid_i) begin
            if (discard_q) begin
              req_n     = 1'b1;  // Stale word gone, issue the redirected request
              discard_n = 1'b0;
            end else begin
              load_instr = 1'b1;
              state_n    = HOLD;
            end
          end
        end
        HOLD: begin
          if (fetch_ready_i) begin
            addr_n  = addr_q + 32'd4;  // Next sequential word
            req_n   = 1'b1;
            state_n = WAIT_RESP;
          end
        end
        default: state_n = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      addr_q    <= '0;
      req_q     <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      state_q   <= state_n;
      addr_q    <= addr_n;
      req_q     <= req_n;
      discard_q <= discard_n;
    end
  end

  // Fetched word
  always_ff @(posedge clk) begin
    if (load_instr) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o   = req_q;
  assign instr_addr_o  = addr_q;
  assign fetch_valid_o = (state_q == HOLD);
  assign fetch_instr_o = instr_q;
  assign fetch_pc_o    = addr_q;    // Unchanged while holding
  assign busy_o        = (state_q == WAIT_RESP);

  // Memory must answer only an outstanding request
  a_rvalid_when_waiting : assert property (
    @(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> (state_q == WAIT_RESP)
  ) else $error("instr_rvalid_i without an outstanding request");

endmodule

//--- verilog/if_id_pipe.sv
// Kill and halt both block IF valid; kill also frees the fetch unit while halt holds it
`timescale 1ns/100ps

module if_id_pipe (
  input  logic                 clk,
  input  logic                 rst_n,

  // Controller
  input  logic                 kill_if_i,
  input  logic                 halt_if_i,
  input  logic                 id_ready_i,

  // From the fetch unit
  input  logic                 fetch_valid_i,
  input  if_stage_pkg::instr_t fetch_instr_i,
  input  if_stage_pkg::addr_t  fetch_pc_i,

  // From the dummy generator
  input  logic                 dummy_insert_i,
  input  if_stage_pkg::instr_t dummy_instr_i,

  output logic                 fetch_ready_o,
  output logic                 instr_issued_o,
  output logic                 if_valid_o,

  // IF/ID register
  output logic                 id_instr_valid_o,
  output if_stage_pkg::instr_t id_instr_o,
  output if_stage_pkg::addr_t  id_pc_o,
  output logic                 id_dummy_o
);

  import if_stage_pkg::*;

  logic   transfer;   // IF to ID handover this cycle
  instr_t instr_sel;  // Word entering ID

  //////////////////////////////////////////////////////////////////////
  // IF handshake
  //////////////////////////////////////////////////////////////////////

  // Something to hand over and the stage is neither killed nor halted
  assign if_valid_o = (fetch_valid_i || dummy_insert_i) && !kill_if_i && !halt_if_i;

  // Kill flushes the held word; a pending dummy goes first
  assign fetch_ready_o = kill_if_i || (id_ready_i && !dummy_insert_i && !halt_if_i);

  assign transfer       = if_valid_o && id_ready_i;
  assign instr_issued_o = transfer;  // Counted by the dummy generator

  assign instr_sel = dummy_insert_i ? dummy_instr_i : fetch_instr_i;

  //////////////////////////////////////////////////////////////////////
  // IF/ID register, frozen while ID stalls
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      id_instr_valid_o <= 1'b0;
      id_instr_o       <= INSTR_NOP;
      id_pc_o          <= '0;
      id_dummy_o       <= 1'b0;
    end else if (transfer) begin
      id_instr_valid_o <= 1'b1;
      id_instr_o       <= instr_sel;
      id_pc_o          <= fetch_pc_i;      // Dummy carries the current fetch PC
      id_dummy_o       <= dummy_insert_i;
    end else if (id_ready_i) begin
      id_instr_valid_o <= 1'b0;  // ID consumed, nothing new
    end
  end

  // ID stall must freeze the whole register
  a_id_stable_on_stall : assert property (
    @(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable({id_instr_valid_o, id_instr_o, id_pc_o, id_dummy_o})
  ) else $error("IF/ID outputs changed while ID was stalled");

endmodule

//--- verilog/if_stage.sv
// Top of the IF stage; no fetch until the first PC set, memory answers each request in order
`timescale 1ns/100ps

module if_stage #(
  parameter int unsigned DUMMY_CNT_W = 4,
  parameter logic [31:0] LFSR_SEED   = 32'h5A3C_96E1
) (
  input  logic                   clk,
  input  logic                   rst_n,

  // Controller
  input  logic                   pc_set_i,
  input  if_stage_pkg::pc_mux_e  pc_mux_i,
  input  logic                   kill_if_i,
  input  logic                   halt_if_i,

  // Target addresses
  input  if_stage_pkg::addr_t    boot_addr_i,
  input  if_stage_pkg::addr_t    jump_target_i,
  input  if_stage_pkg::addr_t    branch_target_i,
  input  if_stage_pkg::addr_t    mepc_i,
  input  if_stage_pkg::addr_t    dpc_i,
  input  if_stage_pkg::addr_t    dm_halt_addr_i,
  input  if_stage_pkg::addr_t    nmi_addr_i,
  input  if_stage_pkg::mtvec_t   mtvec_addr_i,
  input  if_stage_pkg::irq_id_t  irq_id_i,

  // Memory bus
  output logic                   instr_req_o,
  output if_stage_pkg::addr_t    instr_addr_o,
  input  logic                   instr_rvalid_i,
  input  if_stage_pkg::instr_t   instr_rdata_i,

  // IF to ID
  output logic                   if_valid_o,
  input  logic                   id_ready_i,
  output logic                   id_instr_valid_o,
  output if_stage_pkg::instr_t   id_instr_o,
  output if_stage_pkg::addr_t    id_pc_o,
  output logic                   id_dummy_o,

  // Dummy instruction control
  input  logic                   dummy_en_i,
  input  logic [DUMMY_CNT_W-1:0] dummy_every_i,
  output logic                   lfsr_shift_o,

  output logic                   csr_mtvec_init_o,
  output logic                   if_busy_o
);

  import if_stage_pkg::*;

  logic   fetch_valid;   // Fetched word held
  logic   fetch_ready;   // IF takes or flushes it
  instr_t fetch_instr;
  addr_t  fetch_pc;
  logic   dummy_insert;
  instr_t dummy_instr;
  logic   instr_issued;  // IF to ID transfer

  //////////////////////////////////////////////////////////////////////
  // Fetch and dummy generation side by side
  //////////////////////////////////////////////////////////////////////

  fetch_unit u_fetch_unit (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .dpc_i            (dpc_i),
    .dm_halt_addr_i   (dm_halt_addr_i),
    .nmi_addr_i       (nmi_addr_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .fetch_ready_i    (fetch_ready),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .fetch_valid_o    (fetch_valid),
    .fetch_instr_o    (fetch_instr),
    .fetch_pc_o       (fetch_pc),
    .csr_mtvec_init_o (csr_mtvec_init_o),
    .busy_o           (if_busy_o)
  );

  dummy_instr_gen #(
    .DUMMY_CNT_W (DUMMY_CNT_W),
    .LFSR_SEED   (LFSR_SEED)
  ) u_dummy_instr_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .dummy_en_i     (dummy_en_i),
    .dummy_every_i  (dummy_every_i),
    .instr_issued_i (instr_issued),
    .dummy_insert_o (dummy_insert),
    .dummy_instr_o  (dummy_instr),
    .lfsr_shift_o   (lfsr_shift_o)
  );

  // Merges both sources into the IF/ID register
  if_id_pipe u_if_id_pipe (
    .clk              (clk),
    .rst_n            (rst_n),
    .kill_if_i        (kill_if_i),
    .halt_if_i        (halt_if_i),
    .id_ready_i       (id_ready_i),
    .fetch_valid_i    (fetch_valid),
    .fetch_instr_i    (fetch_instr),
    .fetch_pc_i       (fetch_pc),
    .dummy_insert_i   (dummy_insert),
    .dummy_instr_i    (dummy_instr),
    .fetch_ready_o    (fetch_ready),
    .instr_issued_o   (instr_issued),
    .if_valid_o       (if_valid_o),
    .id_instr_valid_o (id_instr_valid_o),
    .id_instr_o       (id_instr_o),
    .id_pc_o          (id_pc_o),
    .id_dummy_o       (id_dummy_o)
  );

endmodule

//--- verilog/if_stage_pkg.sv
// Types and constants for an IF stage that fetches only word aligned 32 bit instructions

package if_stage_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;     // Byte address of an instruction
  typedef logic [31:0] instr_t;    // Raw instruction word
  typedef logic [23:0] mtvec_t;    // Trap vector base, bits [31:8]
  typedef logic [4:0]  irq_id_t;   // Vectored interrupt number
  typedef logic [4:0]  reg_idx_t;  // GPR index

  //////////////////////////////////////////////////////////////////////
  // PC source select
  //////////////////////////////////////////////////////////////////////

  // Nine sources, hence 4 bits
  typedef enum logic [3:0] {
    PC_BOOT      = 4'd0,  // Boot address, word aligned
    PC_JUMP      = 4'd1,  // Jump target from ID
    PC_BRANCH    = 4'd2,  // Branch target from EX
    PC_MRET      = 4'd3,  // Return from trap to mepc
    PC_DRET      = 4'd4,  // Return from debug to dpc
    PC_TRAP_EXC  = 4'd5,  // Exception, mtvec base
    PC_TRAP_IRQ  = 4'd6,  // Interrupt, vectored off mtvec
    PC_TRAP_DBG  = 4'd7,  // Debug halt entry
    PC_NMI       = 4'd8   // Non-maskable interrupt
  } pc_mux_e;

  //////////////////////////////////////////////////////////////////////
  // Fetch sequencer
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE      = 2'd0,  // Waiting for the first PC set
    WAIT_RESP = 2'd1,  // One request outstanding
    HOLD      = 2'd2   // Instruction held until IF takes it
  } fetch_state_e;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_OP = 7'b0110011;  // R-type ALU op

  // addi x0, x0, 0
  localparam instr_t INSTR_NOP = 32'h0000_0013;

endpackage
